// File: source/eeprom_pkg.sv
package eeprom_pkg;

    // host side opcode
    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_e;

    // one queued host command, data ignored on reads
    typedef struct packed
    {
        eeprom_op_e  op;
        logic [10:0] addr;
        logic [7:0]  data;
    } eeprom_cmd_t;

    typedef struct packed
    {
        eeprom_op_e op;
        logic [7:0] rdata;  // zero for writes
        logic       nack;   // some slave ack bit came back high
    } eeprom_rsp_t;

    // bit engine operations
    typedef enum logic [1:0]
    {
        BOP_START = 2'd0,
        BOP_STOP  = 2'd1,
        BOP_WRITE = 2'd2,
        BOP_READ  = 2'd3
    } bit_op_e;

    typedef enum logic [3:0]
    {
        IDLE   = 4'd0,
        START  = 4'd1,
        CTRL_W = 4'd2,
        ADDR   = 4'd3,
        DATA_W = 4'd4,
        RSTART = 4'd5,
        CTRL_R = 4'd6,
        DATA_R = 4'd7,
        STOP   = 4'd8,
        RESP   = 4'd9
    } seq_state_e;

    // device type code, upper nibble of the control byte
    localparam logic [3:0] CTRL_PREFIX = 4'b1010;

endpackage

// File: source/cmd_queue.sv
`timescale 1ns/1ps

module cmd_queue
#(
    parameter int CMD_DEPTH = 4
)
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  cmd_valid,
    input  eeprom_pkg::eeprom_cmd_t cmd,
    input  logic                  q_pop,
    output logic                  q_valid,
    output eeprom_pkg::eeprom_cmd_t q_cmd,
    output logic                  cmd_credit
);

    localparam int PTR_W = $clog2(CMD_DEPTH);

    eeprom_pkg::eeprom_cmd_t mem [CMD_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop_ok;

    assign q_valid = (count != '0);
    assign q_cmd   = mem[rd_ptr];   // oldest entry
    assign pop_ok  = q_pop && q_valid;

    // no full check, host credits keep us from overflowing
    always_ff @(posedge CLK)
    begin
        if (cmd_valid)
        begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end
        else
        begin
            cmd_credit <= pop_ok;  // one credit back per pop
            if (cmd_valid)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, cmd_valid} - {{PTR_W{1'b0}}, pop_ok};
        end
    end

endmodule

// File: source/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine
#(
    parameter int CLK_DIV = 2
)
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic                bop_valid,
    input  eeprom_pkg::bit_op_e bop,
    input  logic [7:0]          bop_wdata,
    input  logic                bop_ack_out,
    input  logic                sda_in,
    output logic                bop_done,
    output logic [7:0]          bop_rdata,
    output logic                bop_ack_in,
    output logic                scl_drive_low,
    output logic                sda_drive_low
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic                busy;
    logic                held;      // SCL parked low between operations
    logic [DIV_W-1:0]    div_cnt;
    logic [1:0]          quarter;
    logic [3:0]          bit_cnt;   // 0..7 data, 8 is the ack bit
    logic                tick;
    logic                last_q;
    logic                scl_next;
    logic                sda_next;

    eeprom_pkg::bit_op_e op_r;
    logic [7:0]          shreg;
    logic                ack_out_r;

    assign tick      = busy && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign last_q    = (quarter == 2'd3) &&
                       ((op_r == eeprom_pkg::BOP_START) ||
                        (op_r == eeprom_pkg::BOP_STOP) ||
                        (bit_cnt == 4'd8));
    assign bop_rdata = shreg;

    // line levels for the current quarter, q0 and q3 have SCL low
    always_comb
    begin
        scl_next = held;
        sda_next = 1'b0;
        if (busy)
        begin
            case (op_r)
                eeprom_pkg::BOP_START:
                begin
                    scl_next = (quarter == 2'd0) || (quarter == 2'd3);
                    sda_next = quarter[1];          // SDA falls with SCL high
                end
                eeprom_pkg::BOP_STOP:
                begin
                    scl_next = (quarter == 2'd0);
                    sda_next = !quarter[1];         // SDA rises with SCL high
                end
                eeprom_pkg::BOP_WRITE:
                begin
                    scl_next = (quarter == 2'd0) || (quarter == 2'd3);
                    sda_next = (bit_cnt < 4'd8) && !shreg[7];
                end
                default:
                begin
                    scl_next = (quarter == 2'd0) || (quarter == 2'd3);
                    sda_next = (bit_cnt == 4'd8) && !ack_out_r;
                end
            endcase
        end
    end

    // operation payload
    always_ff @(posedge CLK)
    begin
        if (!busy && bop_valid)
        begin
            op_r      <= bop;
            shreg     <= bop_wdata;
            ack_out_r <= bop_ack_out;
        end
        else if (tick)
        begin
            if (op_r == eeprom_pkg::BOP_READ && quarter == 2'd2 && bit_cnt < 4'd8)
            begin
                shreg <= {shreg[6:0], sda_in};
            end
            else if (op_r == eeprom_pkg::BOP_WRITE && quarter == 2'd3)
            begin
                shreg <= {shreg[6:0], 1'b0};   // next bit to msb
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy          <= 1'b0;
            held          <= 1'b0;
            div_cnt       <= '0;
            quarter       <= 2'd0;
            bit_cnt       <= 4'd0;
            bop_done      <= 1'b0;
            bop_ack_in    <= 1'b0;
            scl_drive_low <= 1'b0;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            bop_done      <= 1'b0;
            scl_drive_low <= scl_next;
            sda_drive_low <= sda_next;
            if (!busy)
            begin
                if (bop_valid)
                begin
                    busy       <= 1'b1;
                    div_cnt    <= '0;
                    quarter    <= 2'd0;
                    bit_cnt    <= 4'd0;
                    bop_ack_in <= 1'b0;
                end
            end
            else if (tick)
            begin
                div_cnt <= '0;
                quarter <= quarter + 2'd1;
                // sample late in the high phase, bus lags state by a cycle
                if (op_r == eeprom_pkg::BOP_WRITE && quarter == 2'd2 && bit_cnt == 4'd8)
                begin
                    bop_ack_in <= sda_in;
                end
                if (quarter == 2'd3)
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
                if (last_q)
                begin
                    busy     <= 1'b0;
                    bop_done <= 1'b1;
                    held     <= (op_r != eeprom_pkg::BOP_STOP);
                end
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

// File: source/eeprom_sequencer.sv
`timescale 1ns/1ps

module eeprom_sequencer
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    q_valid,
    input  eeprom_pkg::eeprom_cmd_t q_cmd,
    output logic                    q_pop,
    input  logic                    rsp_credit,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    bop_valid,
    output eeprom_pkg::bit_op_e     bop,
    output logic [7:0]              bop_wdata,
    output logic                    bop_ack_out,
    input  logic                    bop_done,
    input  logic [7:0]              bop_rdata,
    input  logic                    bop_ack_in
);

    eeprom_pkg::seq_state_e  state;
    eeprom_pkg::eeprom_cmd_t cmd_r;
    logic [7:0]              rdata_r;
    logic                    nack_r;
    logic                    issued;     // engine op in flight
    logic [7:0]              rsp_cnt;
    logic                    rsp_take;
    logic                    bus_state;
    logic [7:0]              ctrl_byte;

    assign q_pop     = (state == eeprom_pkg::IDLE) && q_valid;
    assign rsp_take  = (state == eeprom_pkg::RESP) && (rsp_cnt != 8'd0);
    assign bus_state = (state != eeprom_pkg::IDLE) && (state != eeprom_pkg::RESP);

    // 1010 a10 a9 a8 r/w
    assign ctrl_byte = {eeprom_pkg::CTRL_PREFIX, cmd_r.addr[10:8],
                        state == eeprom_pkg::CTRL_R};

    assign rsp.op    = cmd_r.op;
    assign rsp.rdata = rdata_r;
    assign rsp.nack  = nack_r;

    assign bop_ack_out = (state == eeprom_pkg::DATA_R);  // master NACKs the single read

    always_comb
    begin
        case (state)
            eeprom_pkg::START,
            eeprom_pkg::RSTART: bop = eeprom_pkg::BOP_START;
            eeprom_pkg::STOP:   bop = eeprom_pkg::BOP_STOP;
            eeprom_pkg::DATA_R: bop = eeprom_pkg::BOP_READ;
            default:            bop = eeprom_pkg::BOP_WRITE;
        endcase
    end

    always_comb
    begin
        case (state)
            eeprom_pkg::CTRL_W,
            eeprom_pkg::CTRL_R: bop_wdata = ctrl_byte;
            eeprom_pkg::ADDR:   bop_wdata = cmd_r.addr[7:0];
            eeprom_pkg::DATA_W: bop_wdata = cmd_r.data;
            default:            bop_wdata = 8'h00;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (q_pop)
        begin
            cmd_r <= q_cmd;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::IDLE;
            issued    <= 1'b0;
            bop_valid <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_cnt   <= 8'd0;
            nack_r    <= 1'b0;
            rdata_r   <= 8'h00;
        end
        else
        begin
            bop_valid <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_cnt   <= rsp_cnt + {7'd0, rsp_credit} - {7'd0, rsp_take};
            if (bus_state && !issued)
            begin
                bop_valid <= 1'b1;
                issued    <= 1'b1;
            end
            else if (bus_state && bop_done)
            begin
                issued <= 1'b0;
                case (state)
                    eeprom_pkg::START:  state <= eeprom_pkg::CTRL_W;
                    eeprom_pkg::RSTART: state <= eeprom_pkg::CTRL_R;
                    eeprom_pkg::CTRL_W:
                    begin
                        nack_r <= bop_ack_in;
                        state  <= bop_ack_in ? eeprom_pkg::STOP : eeprom_pkg::ADDR;
                    end
                    eeprom_pkg::ADDR:
                    begin
                        nack_r <= bop_ack_in;
                        if (bop_ack_in)
                        begin
                            state <= eeprom_pkg::STOP;
                        end
                        else if (cmd_r.op == eeprom_pkg::OP_READ)
                        begin
                            state <= eeprom_pkg::RSTART;
                        end
                        else
                        begin
                            state <= eeprom_pkg::DATA_W;
                        end
                    end
                    eeprom_pkg::DATA_W:
                    begin
                        nack_r <= bop_ack_in;
                        state  <= eeprom_pkg::STOP;
                    end
                    eeprom_pkg::CTRL_R:
                    begin
                        nack_r <= bop_ack_in;
                        state  <= bop_ack_in ? eeprom_pkg::STOP : eeprom_pkg::DATA_R;
                    end
                    eeprom_pkg::DATA_R:
                    begin
                        rdata_r <= bop_rdata;
                        state   <= eeprom_pkg::STOP;
                    end
                    default: state <= eeprom_pkg::RESP;   // stop finished
                endcase
            end
            else if (state == eeprom_pkg::IDLE)
            begin
                if (q_valid)
                begin
                    nack_r  <= 1'b0;
                    rdata_r <= 8'h00;
                    state   <= eeprom_pkg::START;
                end
            end
            else if (rsp_take)
            begin
                rsp_valid <= 1'b1;   // otherwise hold here until host grants room
                state     <= eeprom_pkg::IDLE;
            end
        end
    end

endmodule

// File: source/eeprom_ctrl_top.sv
`timescale 1ns/1ps

module eeprom_ctrl_top
#(
    parameter int CLK_DIV   = 2,
    parameter int CMD_DEPTH = 4
)
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    cmd_valid,
    input  eeprom_pkg::eeprom_cmd_t cmd,
    output logic                    cmd_credit,
    input  logic                    rsp_credit,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    scl_drive_low,
    output logic                    sda_drive_low,
    input  logic                    sda_in
);

    logic                    q_valid;
    logic                    q_pop;
    eeprom_pkg::eeprom_cmd_t q_cmd;

    logic                    bop_valid;
    eeprom_pkg::bit_op_e     bop;
    logic [7:0]              bop_wdata;
    logic                    bop_ack_out;
    logic                    bop_done;
    logic [7:0]              bop_rdata;
    logic                    bop_ack_in;

    cmd_queue #(.CMD_DEPTH(CMD_DEPTH)) u_queue
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .q_pop      (q_pop),
        .q_valid    (q_valid),
        .q_cmd      (q_cmd),
        .cmd_credit (cmd_credit)
    );

    eeprom_sequencer u_seq
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .q_valid     (q_valid),
        .q_cmd       (q_cmd),
        .q_pop       (q_pop),
        .rsp_credit  (rsp_credit),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .bop_valid   (bop_valid),
        .bop         (bop),
        .bop_wdata   (bop_wdata),
        .bop_ack_out (bop_ack_out),
        .bop_done    (bop_done),
        .bop_rdata   (bop_rdata),
        .bop_ack_in  (bop_ack_in)
    );

    i2c_bit_engine #(.CLK_DIV(CLK_DIV)) u_engine
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .bop_valid     (bop_valid),
        .bop           (bop),
        .bop_wdata     (bop_wdata),
        .bop_ack_out   (bop_ack_out),
        .sda_in        (sda_in),
        .bop_done      (bop_done),
        .bop_rdata     (bop_rdata),
        .bop_ack_in    (bop_ack_in),
        .scl_drive_low (scl_drive_low),
        .sda_drive_low (sda_drive_low)
    );

endmodule

// File: dv/i2c_eeprom_model.sv
`timescale 1ns/1ps

module i2c_eeprom_model
#(
    parameter int BUSY_CYCLES = 300
)
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_drive_low,
    output logic busy_at_start,
    output logic busy
);

    typedef enum logic [2:0]
    {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA,
        M_IGNORE
    } slave_state_e;

    logic [7:0]   mem [2048];
    slave_state_e st;
    logic         scl_q;
    logic         sda_q;
    logic [3:0]   rises;    // SCL rising edges since the byte began
    logic [7:0]   shreg;
    logic [7:0]   rbyte;
    logic [2:0]   page;
    logic [7:0]   ptr;
    logic         wrote;
    int           busy_cnt;
    logic [10:0]  addr;

    assign busy = (busy_cnt != 0);
    assign addr = {page, ptr};

    initial
    begin
        for (int a = 0; a < 2048; a++)
        begin
            mem[a] = 8'(a ^ (a >> 3));
        end
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            st            <= M_IDLE;
            scl_q         <= 1'b1;
            sda_q         <= 1'b1;
            sda_drive_low <= 1'b0;
            busy_at_start <= 1'b0;
            busy_cnt      <= 0;
            wrote         <= 1'b0;
            rises         <= 4'd0;
            page          <= 3'd0;
            ptr           <= 8'd0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (busy_cnt != 0)
            begin
                busy_cnt <= busy_cnt - 1;
            end
            if (scl && scl_q && sda_q && !sda)
            begin
                busy_at_start <= busy;   // start condition
                st            <= M_CTRL;
                rises         <= 4'd0;
                sda_drive_low <= 1'b0;
            end
            else if (scl && scl_q && !sda_q && sda)
            begin
                st            <= M_IDLE; // stop, internal write cycle begins
                sda_drive_low <= 1'b0;
                wrote         <= 1'b0;
                if (wrote)
                begin
                    busy_cnt <= BUSY_CYCLES;
                end
            end
            else if (scl && !scl_q)
            begin
                if (rises < 4'd8)
                begin
                    shreg <= {shreg[6:0], sda};
                end
                rises <= rises + 4'd1;
            end
            else if (!scl && scl_q && st == M_RDATA)
            begin
                if (rises >= 4'd1 && rises <= 4'd7)
                begin
                    sda_drive_low <= !rbyte[7 - rises];
                end
                else if (rises == 4'd8)
                begin
                    sda_drive_low <= 1'b0;   // master acks here
                end
                else if (rises == 4'd9)
                begin
                    st <= M_IGNORE;
                end
            end
            else if (!scl && scl_q && st != M_IDLE && st != M_IGNORE && rises == 4'd8)
            begin
                if (st == M_CTRL)
                begin
                    sda_drive_low <= (shreg[7:4] == 4'b1010) && !busy_at_start;
                    page          <= shreg[3:1];
                end
                else
                begin
                    sda_drive_low <= 1'b1;
                end
            end
            else if (!scl && scl_q && st != M_IDLE && st != M_IGNORE && rises == 4'd9)
            begin
                sda_drive_low <= 1'b0;
                rises         <= 4'd0;
                case (st)
                    M_CTRL:
                    begin
                        if (!sda_drive_low)
                        begin
                            st <= M_IGNORE;
                        end
                        else if (shreg[0])
                        begin
                            st            <= M_RDATA;
                            rbyte         <= mem[addr];
                            sda_drive_low <= !mem[addr][7];
                        end
                        else
                        begin
                            st <= M_ADDR;
                        end
                    end
                    M_ADDR:
                    begin
                        ptr <= shreg;
                        st  <= M_WDATA;
                    end
                    default:
                    begin
                        mem[addr] <= shreg;   // single byte, no page write
                        wrote     <= 1'b1;
                        st        <= M_IGNORE;
                    end
                endcase
            end
        end
    end

endmodule

// File: dv/eeprom_ctrl_sva.sv
`timescale 1ns/1ps

module eeprom_ctrl_sva
#(
    parameter int CMD_DEPTH = 4
)
(
    input logic                CLK,
    input logic                RESET,
    input logic                cmd_valid,
    input logic                cmd_credit,
    input logic                rsp_credit,
    input logic                rsp_valid,
    input logic                scl_drive_low,
    input logic                sda_in,
    input eeprom_pkg::bit_op_e engine_op
);

    int rsp_avail;  // granted minus delivered
    int cmd_out;    // host commands not yet credited back

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            rsp_avail <= 0;
            cmd_out   <= 0;
        end
        else
        begin
            rsp_avail <= rsp_avail + int'(rsp_credit) - int'(rsp_valid);
            cmd_out   <= cmd_out + int'(cmd_valid) - int'(cmd_credit);
        end
    end

    // SDA may move under a high SCL only while the engine runs a start or stop
    sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (!scl_drive_low && $past(!scl_drive_low) && !$stable(sda_in)) |->
            ((engine_op == eeprom_pkg::BOP_START) || (engine_op == eeprom_pkg::BOP_STOP)))
        else $error("SDA changed while SCL was high outside a start or stop");

    rsp_needs_credit: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |-> (rsp_avail > 0))
        else $error("rsp_valid without a response credit");

    credit_not_extra: assert property (@(posedge CLK) disable iff (RESET)
        cmd_credit |-> (cmd_out > 0))
        else $error("more command credits returned than commands issued");

    cmd_within_credit: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> (cmd_out < CMD_DEPTH))
        else $error("command issued without a credit");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_sva #(.CMD_DEPTH(CMD_DEPTH)) u_sva
(
    .CLK           (CLK),
    .RESET         (RESET),
    .cmd_valid     (cmd_valid),
    .cmd_credit    (cmd_credit),
    .rsp_credit    (rsp_credit),
    .rsp_valid     (rsp_valid),
    .scl_drive_low (scl_drive_low),
    .sda_in        (sda_in),
    .engine_op     (u_engine.op_r)
);

// File: dv/eeprom_ctrl_tb.sv
`timescale 1ns/1ps

module eeprom_ctrl_tb;

    localparam int CLK_DIV     = 2;
    localparam int CMD_DEPTH   = 4;
    localparam int BUSY_CYCLES = 300;
    localparam int WAIT_LIMIT  = 20000;

    logic                    CLK;
    logic                    RESET;
    logic                    cmd_valid;
    eeprom_pkg::eeprom_cmd_t cmd;
    logic                    cmd_credit;
    logic                    rsp_credit;
    logic                    rsp_valid;
    eeprom_pkg::eeprom_rsp_t rsp;
    logic                    scl_drive_low;
    logic                    sda_drive_low;
    logic                    sda_in;
    logic                    slave_sda_low;
    logic                    scl_line;
    logic                    slave_busy_at_start;
    logic                    slave_busy;

    eeprom_pkg::eeprom_cmd_t exp_q[$];
    logic [10:0]             written_q[$];
    logic [7:0]              ref_mem [2048];
    int seed = 32'h4561;
    int cmds_issued = 0;
    int credits_back = 0;
    int rsps_seen = 0;
    int peak_out = 0;
    int errors = 0;
    int timeouts = 0;
    int busy_nacks = 0;
    int good_reads = 0;

    // open-drain wired-AND of master and slave
    assign scl_line = !scl_drive_low;
    assign sda_in   = !(sda_drive_low || slave_sda_low);

    eeprom_ctrl_top #(.CLK_DIV(CLK_DIV), .CMD_DEPTH(CMD_DEPTH)) UUT
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_credit    (cmd_credit),
        .rsp_credit    (rsp_credit),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .scl_drive_low (scl_drive_low),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    i2c_eeprom_model #(.BUSY_CYCLES(BUSY_CYCLES)) eeprom
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl_line),
        .sda           (sda_in),
        .sda_drive_low (slave_sda_low),
        .busy_at_start (slave_busy_at_start),
        .busy          (slave_busy)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic check_response();
        eeprom_pkg::eeprom_cmd_t c;
        eeprom_pkg::eeprom_rsp_t e;
        if (exp_q.size() == 0)
        begin
            errors++;
            $display("response arrived with no command outstanding");
        end
        else
        begin
            c       = exp_q.pop_front();
            e.op    = c.op;
            e.nack  = slave_busy_at_start;   // device busy NACKs the control byte
            e.rdata = (c.op == eeprom_pkg::OP_READ && !e.nack) ? ref_mem[c.addr] : 8'h00;
            if (c.op == eeprom_pkg::OP_WRITE && !e.nack)
            begin
                ref_mem[c.addr] = c.data;
            end
            if (e.nack)
            begin
                busy_nacks++;
            end
            else if (c.op == eeprom_pkg::OP_READ)
            begin
                good_reads++;
            end
            assert (rsp == e)
            else
            begin
                errors++;
                $display("Mismatch rsp: got %h expected %h", rsp, e);
            end
        end
    endtask

    // response and credit monitor
    always @(posedge CLK)
    begin
        if (!RESET)
        begin
            if (cmd_credit)
            begin
                credits_back++;
            end
            if (rsp_valid)
            begin
                rsps_seen++;
                check_response();
            end
        end
    end

    task automatic issue_cmd(input eeprom_pkg::eeprom_op_e op, input logic [10:0] addr,
                             input logic [7:0] data, input logic grant);
        int n;
        n = 0;
        @(negedge CLK);
        while (cmds_issued - credits_back >= CMD_DEPTH && n < WAIT_LIMIT)
        begin
            @(negedge CLK);
            n++;
        end
        if (n >= WAIT_LIMIT)
        begin
            timeouts++;
            $display("timed out waiting for a command credit");
        end
        cmd_valid  = 1'b1;
        cmd.op     = op;
        cmd.addr   = addr;
        cmd.data   = data;
        rsp_credit = grant;
        exp_q.push_back(cmd);
        cmds_issued++;
        if (cmds_issued - credits_back > peak_out)
        begin
            peak_out = cmds_issued - credits_back;
        end
        @(negedge CLK);
        cmd_valid  = 1'b0;
        rsp_credit = 1'b0;
    endtask

    task automatic wait_responses(input int target);
        int n;
        n = 0;
        while (rsps_seen < target && n < WAIT_LIMIT)
        begin
            @(negedge CLK);
            n++;
        end
        if (n >= WAIT_LIMIT)
        begin
            timeouts++;
            $display("timed out waiting for response %0d", target);
        end
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (slave_busy && n < WAIT_LIMIT)
        begin
            @(negedge CLK);
            n++;
        end
        if (n >= WAIT_LIMIT)
        begin
            timeouts++;
            $display("timed out waiting for the write cycle to end");
        end
    endtask

    task automatic hold_no_response(input int cycles, input int count);
        for (int k = 0; k < cycles; k++)
        begin
            @(negedge CLK);
            assert (rsps_seen == count)
            else
            begin
                errors++;
                $display("a response appeared without a response credit");
                break;
            end
        end
    endtask

    initial
    begin
        logic [31:0] r;
        logic [10:0] a;
        logic [7:0]  offset;
        int          base;
        int          n;
        RESET      = 1'b1;
        cmd_valid  = 1'b0;
        cmd        = '0;
        rsp_credit = 1'b0;
        repeat (3) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        assert (!scl_drive_low && !sda_drive_low && !cmd_credit && !rsp_valid)
        else
        begin
            errors++;
            $display("bus or handshake outputs not idle after reset");
        end

        // write then read, one per page at the same offset
        r      = $random(seed);
        offset = r[7:0];
        for (int i = 0; i < 8; i++)
        begin
            r = $random(seed);
            a = {3'(i), offset};
            wait_not_busy();
            issue_cmd(eeprom_pkg::OP_WRITE, a, r[15:8], 1'b1);
            wait_responses(cmds_issued);
            wait_not_busy();
            issue_cmd(eeprom_pkg::OP_READ, a, 8'h00, 1'b1);
            wait_responses(cmds_issued);
            written_q.push_back(a);
        end

        // busy window, retried afterwards
        a = written_q[0];
        issue_cmd(eeprom_pkg::OP_WRITE, a, 8'h5a, 1'b1);
        wait_responses(cmds_issued);
        issue_cmd(eeprom_pkg::OP_WRITE, a, 8'ha5, 1'b1);
        wait_responses(cmds_issued);
        issue_cmd(eeprom_pkg::OP_READ, a, 8'h00, 1'b1);
        wait_responses(cmds_issued);
        wait_not_busy();
        issue_cmd(eeprom_pkg::OP_READ, a, 8'h00, 1'b1);
        issue_cmd(eeprom_pkg::OP_WRITE, a, 8'ha5, 1'b1);
        wait_responses(cmds_issued);
        wait_not_busy();
        issue_cmd(eeprom_pkg::OP_READ, a, 8'h00, 1'b1);
        wait_responses(cmds_issued);

        // back-to-back reads past the credit limit
        for (int i = 0; i <= CMD_DEPTH; i++)
        begin
            issue_cmd(eeprom_pkg::OP_READ, written_q[i + 1], 8'h00, 1'b1);
        end
        wait_responses(cmds_issued);
        assert (peak_out == CMD_DEPTH && credits_back == cmds_issued)
        else
        begin
            errors++;
            $display("command credits not exhausted or not all returned");
        end

        // response back-pressure
        base = rsps_seen;
        for (int i = 0; i < 3; i++)
        begin
            issue_cmd(eeprom_pkg::OP_READ, written_q[i + 5], 8'h00, 1'b0);
        end
        n = 0;
        while (credits_back < cmds_issued - 2 && n < WAIT_LIMIT)
        begin
            @(negedge CLK);
            n++;
        end
        if (n >= WAIT_LIMIT)
        begin
            timeouts++;
            $display("timed out waiting for the first pop");
        end
        hold_no_response(700, base);
        for (int i = 0; i < 3; i++)
        begin
            rsp_credit = 1'b1;
            @(negedge CLK);
            rsp_credit = 1'b0;
            wait_responses(base + i + 1);
            hold_no_response(700, base + i + 1);
        end

        assert (busy_nacks > 0 && good_reads > 0 && exp_q.size() == 0)
        else
        begin
            errors++;
            $display("busy NACK or good read never seen, or responses missing");
        end
        $display("errors %0d timeouts %0d commands %0d responses %0d credits %0d",
                 errors, timeouts, cmds_issued, rsps_seen, credits_back);
        if (errors == 0 && timeouts == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: list.f
source/eeprom_pkg.sv
source/cmd_queue.sv
source/i2c_bit_engine.sv
source/eeprom_sequencer.sv
source/eeprom_ctrl_top.sv
dv/i2c_eeprom_model.sv
dv/eeprom_ctrl_sva.sv
dv/eeprom_ctrl_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module eeprom_ctrl_tb -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
